/* isa_pkg.sv */
package isa_pkg;

  typedef logic [31:0] word_t;      // data word
  typedef logic [4:0]  reg_addr_t;  // register index

  typedef enum logic [5:0] {
    OP_SPECIAL = 6'h00,             // r-type, funct selects op
    OP_J       = 6'h02,
    OP_BEQ     = 6'h04,
    OP_BNE     = 6'h05,
    OP_ADDIU   = 6'h09,
    OP_LW      = 6'h23,
    OP_SW      = 6'h2b
  } opcode_t;

  typedef enum logic [5:0] {
    FN_ADDU = 6'h21,
    FN_SUBU = 6'h23,
    FN_AND  = 6'h24,
    FN_OR   = 6'h25,
    FN_SLT  = 6'h2a                 // signed compare
  } funct_t;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_SLT
  } alu_op_t;

  localparam word_t nop_word = 32'h0000_0000;  // sll r0,r0,0

  // instruction field extractors
  function automatic logic [5:0] f_opcode(word_t inst);
    return inst[31:26];
  endfunction

  function automatic reg_addr_t f_rs(word_t inst);
    return inst[25:21];
  endfunction

  function automatic reg_addr_t f_rt(word_t inst);
    return inst[20:16];
  endfunction

  function automatic reg_addr_t f_rd(word_t inst);
    return inst[15:11];
  endfunction

  function automatic logic [5:0] f_funct(word_t inst);
    return inst[5:0];
  endfunction

  function automatic logic [15:0] f_imm(word_t inst);
    return inst[15:0];
  endfunction

  function automatic logic [25:0] f_jaddr(word_t inst);
    return inst[25:0];
  endfunction

endpackage

/* pipe_pkg.sv */
package pipe_pkg;
  import isa_pkg::*;

  typedef enum logic [1:0] {
    FWD_NONE = 2'd0,              // operand from register file
    FWD_MEM  = 2'd1,              // alu result in memory stage
    FWD_WB   = 2'd2               // write value in writeback
  } fwd_sel_t;

  // decode -> execute
  typedef struct packed {
    logic        en;              // valid instruction
    logic        wr_reg;          // writes register file
    logic        mem_wr;          // sw
    logic        mem_to_reg;      // lw
    alu_op_t     alu_op;
    logic        alu_imm;         // source b is the immediate
    logic        beq;
    logic        bne;
    logic        jump;
    reg_addr_t   rs;
    reg_addr_t   rt;
    reg_addr_t   dst;             // rd or rt
    word_t       rd1;
    word_t       rd2;
    word_t       imm;             // sign extended
    logic [25:0] jaddr;           // j target field
    word_t       pc_plus4;
  } id_ex_t;

  // execute -> memory
  typedef struct packed {
    logic        wr_reg;
    logic        mem_to_reg;
    reg_addr_t   dst;
    word_t       alu_res;         // also the data address
  } ex_mem_t;

endpackage

/* hazard_if.sv */
`timescale 1ns/1ps

interface hazard_if import isa_pkg::*, pipe_pkg::*; (
  input logic clk,
  input logic reset,
  input logic run
);
  reg_addr_t rs_d;              // sources of instruction in decode
  reg_addr_t rt_d;
  reg_addr_t rs_e;              // sources of instruction in execute
  reg_addr_t rt_e;
  reg_addr_t dst_e;
  logic      load_e;            // lw in execute
  reg_addr_t dst_m;
  logic      wr_m;
  reg_addr_t dst_w;
  logic      wr_w;
  fwd_sel_t  fwd_a;
  fwd_sel_t  fwd_b;
  logic      stall;             // load-use

  modport decode (output rs_d, rt_d);
  modport execute (output rs_e, rt_e, dst_e, load_e, input fwd_a, fwd_b);
  modport writeback (output dst_m, wr_m, dst_w, wr_w);
  modport hazard (input clk, reset, run, rs_d, rt_d, rs_e, rt_e, dst_e, load_e,
                  input dst_m, wr_m, dst_w, wr_w, output fwd_a, fwd_b, stall);
endinterface

/* regfile.sv */
`timescale 1ns/1ps

module regfile import isa_pkg::*; (
  input  logic      clk,
  input  logic      we,
  input  reg_addr_t ra1,
  input  reg_addr_t ra2,
  input  reg_addr_t wa,
  input  word_t     wd,
  output word_t     rd1,
  output word_t     rd2
);
  word_t regs [32];

  always_ff @(posedge clk) begin
    if (we) regs[wa] <= wd;         // r0 written but never read
  end

  // same-cycle write bypass
  assign rd1 = (ra1 == '0)            ? '0 :
               (we && (wa == ra1))    ? wd : regs[ra1];
  assign rd2 = (ra2 == '0)            ? '0 :
               (we && (wa == ra2))    ? wd : regs[ra2];

  a_write_known: assert property (@(posedge clk) we |-> !$isunknown({wa, wd}))
    else $error("register write with unknown index or data");

endmodule

/* fetch_stage.sv */
`timescale 1ns/1ps

module fetch_stage import isa_pkg::*; #(
  parameter word_t reset_pc = 32'h0000_0000
) (
  input  logic        clk,
  input  logic        reset,
  input  logic        run,
  input  logic        stall,
  input  logic        branch_take,
  input  word_t       branch_target,
  input  word_t       imem_data,
  output logic [29:0] imem_addr,
  output word_t       inst_d,
  output word_t       pc_plus4_d
);
  word_t pc;                        // address of the word on imem_data
  word_t next_pc;
  word_t inst_f;
  logic  fetch_ok;                  // low until the first word is back
  logic  advance;

  assign advance = run & ~stall;
  assign next_pc = !fetch_ok   ? pc :           // first fetch presents reset_pc
                   branch_take ? branch_target :
                                 pc + 32'd4;
  assign imem_addr = advance ? next_pc[31:2] : pc[31:2];  // refetch pc while held
  assign inst_f = (fetch_ok & ~branch_take) ? imem_data : nop_word;  // squash

  always_ff @(posedge clk) begin
    if (reset) begin
      pc       <= reset_pc;
      fetch_ok <= 1'b0;
      inst_d   <= nop_word;
    end else if (advance) begin
      pc       <= next_pc;
      fetch_ok <= 1'b1;
      inst_d   <= inst_f;
    end
  end

  always_ff @(posedge clk) begin
    if (advance) pc_plus4_d <= pc + 32'd4;  // link for branch target math
  end

  a_pc_aligned: assert property (@(posedge clk) disable iff (reset) pc[1:0] == 2'b00)
    else $error("pc not word aligned: %h", pc);

endmodule

/* decode_stage.sv */
`timescale 1ns/1ps

module decode_stage import isa_pkg::*, pipe_pkg::*; (
  input  logic      clk,
  input  logic      reset,
  input  logic      run,
  input  logic      stall,
  input  word_t     inst_d,
  input  word_t     pc_plus4_d,
  input  logic      wb_we,
  input  reg_addr_t wb_dst,
  input  word_t     wb_data,
  hazard_if.decode  hz,
  output id_ex_t    id_ex
);
  id_ex_t id_ex_d;
  word_t  rd1;
  word_t  rd2;
  logic   dst_rd;                   // r-type writes rd

  assign hz.rs_d = f_rs(inst_d);
  assign hz.rt_d = f_rt(inst_d);

  regfile regfile_inst (
    .clk, .we(wb_we),
    .ra1(f_rs(inst_d)), .ra2(f_rt(inst_d)),
    .wa(wb_dst), .wd(wb_data),
    .rd1, .rd2
  );

  always_comb begin
    id_ex_d    = '0;
    id_ex_d.en = 1'b1;
    dst_rd     = 1'b0;
    case (f_opcode(inst_d))
      OP_SPECIAL: begin
        id_ex_d.wr_reg = 1'b1;
        dst_rd         = 1'b1;
        case (f_funct(inst_d))
          FN_ADDU: id_ex_d.alu_op = ALU_ADD;
          FN_SUBU: id_ex_d.alu_op = ALU_SUB;
          FN_AND:  id_ex_d.alu_op = ALU_AND;
          FN_OR:   id_ex_d.alu_op = ALU_OR;
          FN_SLT:  id_ex_d.alu_op = ALU_SLT;
          default: begin              // nop and unknown functs
            id_ex_d.en     = 1'b0;
            id_ex_d.wr_reg = 1'b0;
          end
        endcase
      end
      OP_ADDIU: begin
        id_ex_d.wr_reg  = 1'b1;
        id_ex_d.alu_imm = 1'b1;
      end
      OP_LW: begin
        id_ex_d.wr_reg     = 1'b1;
        id_ex_d.mem_to_reg = 1'b1;
        id_ex_d.alu_imm    = 1'b1;    // base + offset
      end
      OP_SW: begin
        id_ex_d.mem_wr  = 1'b1;
        id_ex_d.alu_imm = 1'b1;
      end
      OP_BEQ:  id_ex_d.beq  = 1'b1;
      OP_BNE:  id_ex_d.bne  = 1'b1;
      OP_J:    id_ex_d.jump = 1'b1;
      default: id_ex_d.en   = 1'b0;   // undefined opcode runs as nop
    endcase
    id_ex_d.rs       = f_rs(inst_d);
    id_ex_d.rt       = f_rt(inst_d);
    id_ex_d.dst      = dst_rd ? f_rd(inst_d) : f_rt(inst_d);
    id_ex_d.rd1      = rd1;
    id_ex_d.rd2      = rd2;
    id_ex_d.imm      = {{16{inst_d[15]}}, f_imm(inst_d)};  // sign extend
    id_ex_d.jaddr    = f_jaddr(inst_d);
    id_ex_d.pc_plus4 = pc_plus4_d;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      id_ex <= '0;
    end else if (run) begin
      id_ex <= stall ? '0 : id_ex_d;  // bubble on load-use
    end
  end

endmodule

/* execute_stage.sv */
`timescale 1ns/1ps

module execute_stage import isa_pkg::*, pipe_pkg::*; (
  input  logic        clk,
  input  logic        reset,
  input  logic        run,
  input  id_ex_t      id_ex,
  input  word_t       wb_data,
  hazard_if.execute   hz,
  output logic        branch_take,
  output word_t       branch_target,
  output logic [29:0] dmem_addr,
  output logic        dmem_we,
  output logic        dmem_re,
  output word_t       dmem_wdata,
  output ex_mem_t     ex_mem
);
  word_t src_a;                     // forwarded rs
  word_t src_b_reg;                 // forwarded rt
  word_t src_b;
  word_t alu_res;
  logic  regs_equal;

  assign hz.rs_e   = id_ex.rs;
  assign hz.rt_e   = id_ex.rt;
  assign hz.dst_e  = id_ex.dst;
  assign hz.load_e = id_ex.en & id_ex.mem_to_reg;

  always_comb begin
    case (hz.fwd_a)
      FWD_MEM: src_a = ex_mem.alu_res;
      FWD_WB:  src_a = wb_data;
      default: src_a = id_ex.rd1;
    endcase
    case (hz.fwd_b)
      FWD_MEM: src_b_reg = ex_mem.alu_res;
      FWD_WB:  src_b_reg = wb_data;
      default: src_b_reg = id_ex.rd2;
    endcase
  end

  assign src_b = id_ex.alu_imm ? id_ex.imm : src_b_reg;

  always_comb begin
    case (id_ex.alu_op)
      ALU_ADD: alu_res = src_a + src_b;
      ALU_SUB: alu_res = src_a - src_b;
      ALU_AND: alu_res = src_a & src_b;
      ALU_OR:  alu_res = src_a | src_b;
      ALU_SLT: alu_res = {31'b0, $signed(src_a) < $signed(src_b)};
      default: alu_res = '0;
    endcase
  end

  // branch resolution on forwarded operands
  assign regs_equal  = (src_a == src_b_reg);
  assign branch_take = id_ex.en & (id_ex.jump | (id_ex.beq & regs_equal) |
                                   (id_ex.bne & ~regs_equal));
  assign branch_target = id_ex.jump ? {id_ex.pc_plus4[31:28], id_ex.jaddr, 2'b00}
                                    : id_ex.pc_plus4 + {id_ex.imm[29:0], 2'b00};

  assign dmem_addr  = alu_res[31:2];
  assign dmem_we    = id_ex.en & id_ex.mem_wr & run;  // no store while paused
  assign dmem_re    = id_ex.en & id_ex.mem_to_reg;
  assign dmem_wdata = src_b_reg;

  always_ff @(posedge clk) begin
    if (reset) begin
      ex_mem <= '0;
    end else if (run) begin
      ex_mem.wr_reg     <= id_ex.en & id_ex.wr_reg;
      ex_mem.mem_to_reg <= id_ex.en & id_ex.mem_to_reg;
      ex_mem.dst        <= id_ex.dst;
      ex_mem.alu_res    <= alu_res;
    end
  end

  a_fwd_legal: assert property (@(posedge clk) disable iff (reset)
    (hz.fwd_a != 2'b11) && (hz.fwd_b != 2'b11))
    else $error("unused forward select a=%0d b=%0d", hz.fwd_a, hz.fwd_b);

endmodule

/* writeback_stage.sv */
`timescale 1ns/1ps

module writeback_stage import isa_pkg::*, pipe_pkg::*; (
  input  logic       clk,
  input  logic       reset,
  input  logic       run,
  input  ex_mem_t    ex_mem,
  input  word_t      dmem_rdata,
  hazard_if.writeback hz,
  output logic       wb_we,
  output reg_addr_t  wb_dst,
  output word_t      wb_data
);
  logic  mem_to_reg_w;
  word_t alu_res_w;
  word_t load_w;                    // data memory word of a lw

  assign hz.dst_m = ex_mem.dst;
  assign hz.wr_m  = ex_mem.wr_reg;
  assign hz.dst_w = wb_dst;
  assign hz.wr_w  = wb_we;

  always_ff @(posedge clk) begin
    if (reset) begin
      wb_we        <= 1'b0;
      mem_to_reg_w <= 1'b0;
    end else if (run) begin
      wb_we        <= ex_mem.wr_reg;
      mem_to_reg_w <= ex_mem.mem_to_reg;
    end
  end

  always_ff @(posedge clk) begin
    if (run) begin
      wb_dst    <= ex_mem.dst;
      alu_res_w <= ex_mem.alu_res;
      load_w    <= dmem_rdata;      // valid in the load's memory cycle
    end
  end

  assign wb_data = mem_to_reg_w ? load_w : alu_res_w;

endmodule

/* hazard_unit.sv */
`timescale 1ns/1ps

module hazard_unit import isa_pkg::*, pipe_pkg::*; (
  hazard_if.hazard hz
);
  // memory stage wins over writeback, r0 never forwarded
  function automatic fwd_sel_t fwd_for(reg_addr_t src, logic wr_m, reg_addr_t dst_m,
                                       logic wr_w, reg_addr_t dst_w);
    if (wr_m && (dst_m != '0) && (dst_m == src)) begin
      return FWD_MEM;
    end else if (wr_w && (dst_w != '0) && (dst_w == src)) begin
      return FWD_WB;
    end
    return FWD_NONE;
  endfunction

  assign hz.fwd_a = fwd_for(hz.rs_e, hz.wr_m, hz.dst_m, hz.wr_w, hz.dst_w);
  assign hz.fwd_b = fwd_for(hz.rt_e, hz.wr_m, hz.dst_m, hz.wr_w, hz.dst_w);

  // lw in execute feeding the instruction in decode
  assign hz.stall = hz.load_e && (hz.dst_e != '0) &&
                    ((hz.dst_e == hz.rs_d) || (hz.dst_e == hz.rt_d));

  // the bubble clears load_e, so a taken stall lasts one cycle
  a_stall_once: assert property (@(posedge hz.clk) disable iff (hz.reset)
    (hz.stall && hz.run) |=> !hz.stall)
    else $error("load-use stall held for two cycles");

endmodule

/* cpu_core.sv */
`timescale 1ns/1ps

module cpu_core import isa_pkg::*, pipe_pkg::*; #(
  parameter word_t reset_pc = 32'h0000_0000
) (
  input  logic        clk,
  input  logic        reset,
  input  logic        run,
  output logic [29:0] imem_addr,    // word address
  input  word_t       imem_data,
  output logic [29:0] dmem_addr,    // word address
  output logic        dmem_we,
  output word_t       dmem_wdata,
  output logic        dmem_re,
  input  word_t       dmem_rdata
);
  word_t     inst_d;                // fetch -> decode
  word_t     pc_plus4_d;
  id_ex_t    id_ex;                 // decode -> execute
  ex_mem_t   ex_mem;                // execute -> writeback
  logic      branch_take;           // execute -> fetch
  word_t     branch_target;
  logic      wb_we;                 // writeback -> regfile
  reg_addr_t wb_dst;
  word_t     wb_data;

  hazard_if hz_if (.clk(clk), .reset(reset), .run(run));

  fetch_stage #(.reset_pc(reset_pc)) fetch_inst (
    .clk, .reset, .run,
    .stall         (hz_if.stall),
    .branch_take, .branch_target,
    .imem_data, .imem_addr,
    .inst_d, .pc_plus4_d
  );

  decode_stage decode_inst (
    .clk, .reset, .run,
    .stall (hz_if.stall),
    .inst_d, .pc_plus4_d,
    .wb_we, .wb_dst, .wb_data,
    .hz    (hz_if.decode),
    .id_ex
  );

  execute_stage execute_inst (
    .clk, .reset, .run,
    .id_ex, .wb_data,
    .hz    (hz_if.execute),
    .branch_take, .branch_target,
    .dmem_addr, .dmem_we, .dmem_re, .dmem_wdata,
    .ex_mem
  );

  writeback_stage writeback_inst (
    .clk, .reset, .run,
    .ex_mem, .dmem_rdata,
    .hz    (hz_if.writeback),
    .wb_we, .wb_dst, .wb_data
  );

  hazard_unit hazard_inst (.hz(hz_if.hazard));

endmodule

/* tb_clock.sv */
`timescale 1ns/1ps

module tb_clock #(
  parameter int half_period  = 5,   // 10 ns clock
  parameter int reset_cycles = 3
) (
  output logic clk,
  output logic reset
);
  initial begin
    clk = 1'b0;
    forever #(half_period) clk = ~clk;
  end

  initial begin
    reset = 1'b1;
    repeat (reset_cycles) @(posedge clk);
    reset <= 1'b0;                  // released on a rising edge
  end

endmodule

/* tb_cpu_core.sv */
`timescale 1ns/1ps

module tb_cpu_core import isa_pkg::*; ();
  localparam word_t reset_pc   = 32'h0000_0080;
  localparam int    base_word  = 32;               // reset_pc in words
  localparam int    max_stores = 24;

  localparam logic [5:0] op_j     = 6'h02;
  localparam logic [5:0] op_beq   = 6'h04;
  localparam logic [5:0] op_bne   = 6'h05;
  localparam logic [5:0] op_addiu = 6'h09;
  localparam logic [5:0] op_lw    = 6'h23;
  localparam logic [5:0] op_sw    = 6'h2b;
  localparam logic [5:0] fn_addu  = 6'h21;
  localparam logic [5:0] fn_subu  = 6'h23;
  localparam logic [5:0] fn_and   = 6'h24;
  localparam logic [5:0] fn_or    = 6'h25;
  localparam logic [5:0] fn_slt   = 6'h2a;

  logic        clk;
  logic        reset;
  logic        run = 1'b1;
  logic [29:0] imem_addr;
  word_t       imem_data = '0;
  logic [29:0] dmem_addr;
  logic        dmem_we;
  word_t       dmem_wdata;
  logic        dmem_re;
  word_t       dmem_rdata = '0;

  word_t       imem [128];
  word_t       dmem [64];
  word_t       data_words [8];                     // own copy of dmem 0..7
  logic [29:0] exp_addr [max_stores];              // expected stores, program order
  word_t       exp_data [max_stores];
  string       exp_name [max_stores];
  int          tail = 0;
  int          head = 0;                           // next store due
  int          emit_idx = 0;
  int          value_errors = 0;
  int          other_errors = 0;
  bit          timed_out = 1'b0;

  tb_clock #(.half_period(5), .reset_cycles(3)) clock_inst (.clk, .reset);

  cpu_core #(.reset_pc(reset_pc)) cpu_core_inst (
    .clk, .reset, .run,
    .imem_addr, .imem_data,
    .dmem_addr, .dmem_we, .dmem_wdata, .dmem_re, .dmem_rdata
  );

  function automatic word_t enc_r(logic [5:0] funct, int rs, int rt, int rd);
    return {6'h00, 5'(rs), 5'(rt), 5'(rd), 5'h00, funct};
  endfunction

  function automatic word_t enc_i(logic [5:0] op, int rs, int rt, int imm);
    return {op, 5'(rs), 5'(rt), 16'(imm)};
  endfunction

  function automatic word_t fill_word(logic [5:0] addr);
    return {16'hd0d0, 10'h000, addr};
  endfunction

  always @(posedge clk) begin
    imem_data <= imem[imem_addr[6:0]];             // one cycle read
  end

  always @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < 64; i++) begin
        if (i < 8) dmem[i] <= data_words[i[2:0]];
        else dmem[i] <= fill_word(6'(i));
      end
    end else begin
      if (dmem_we) dmem[dmem_addr[5:0]] <= dmem_wdata;
      if (dmem_re) dmem_rdata <= dmem[dmem_addr[5:0]];  // read only on a load
    end
  end

  always @(posedge clk) begin
    if (!reset && dmem_we && head < tail) head <= head + 1;  // pop
  end

  a_reset_quiet: assert property (@(posedge clk) $fell(reset) |-> !dmem_we && !dmem_re)
    else begin
      value_errors++;
      $display("ERROR reset: expected we/re 0/0 actual %b/%b",
               $sampled(dmem_we), $sampled(dmem_re));
    end

  a_first_fetch: assert property (@(posedge clk) $fell(reset) |-> imem_addr == reset_pc[31:2])
    else begin
      value_errors++;
      $display("ERROR reset: expected imem_addr %h actual %h",
               reset_pc[31:2], $sampled(imem_addr));
    end

  a_store_expected: assert property (@(posedge clk) disable iff (reset) dmem_we |-> head < tail)
    else begin
      other_errors++;
      $display("store to word %h was not expected", $sampled(dmem_addr));
    end

  a_store_addr: assert property (@(posedge clk) disable iff (reset)
    (dmem_we && head < tail) |-> dmem_addr == exp_addr[head])
    else begin
      value_errors++;
      $display("ERROR %s: expected addr %h actual %h", exp_name[$sampled(head)],
               exp_addr[$sampled(head)], $sampled(dmem_addr));
    end

  a_store_data: assert property (@(posedge clk) disable iff (reset)
    (dmem_we && head < tail) |-> dmem_wdata == exp_data[head])
    else begin
      value_errors++;
      $display("ERROR %s: expected data %h actual %h", exp_name[$sampled(head)],
               exp_data[$sampled(head)], $sampled(dmem_wdata));
    end

  a_pause_quiet: assert property (@(posedge clk) disable iff (reset) !run |-> !dmem_we)
    else begin
      other_errors++;
      $display("a store was issued while run was low");
    end

  task automatic emit(input word_t inst);
    imem[base_word + emit_idx] = inst;
    emit_idx++;
  endtask

  task automatic emit_checked_sw(input string name, input int rt, input int byte_addr,
                                 input word_t data);
    emit(enc_i(op_sw, 0, rt, byte_addr));
    exp_name[tail] = name;
    exp_addr[tail] = 30'(byte_addr >> 2);
    exp_data[tail] = data;
    tail++;
  endtask

  task automatic build_program();
    word_t a;
    word_t b;
    word_t sum;
    word_t slt_ab;
    word_t slt_ba;
    word_t r10;
    a = data_words[0];
    b = data_words[1];
    sum = a + b;
    slt_ab = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
    slt_ba = ($signed(b) < $signed(a)) ? 32'd1 : 32'd0;
    r10 = sum + a;
    for (int i = 0; i < 128; i++) imem[i] = {6'h3f, 19'h0, 7'(i)};  // undefined op, no effect
    emit(enc_i(op_lw, 0, 1, 0));
    emit(enc_i(op_lw, 0, 2, 4));
    emit(32'h0000_0000);
    emit(enc_r(fn_addu, 1, 2, 3));                 // r2 from writeback
    emit_checked_sw("alu_addu", 3, 64, sum);
    emit(enc_r(fn_subu, 1, 2, 4));
    emit_checked_sw("alu_subu", 4, 68, a - b);
    emit(enc_r(fn_and, 1, 2, 5));
    emit_checked_sw("alu_and", 5, 72, a & b);
    emit(enc_r(fn_or, 1, 2, 6));
    emit_checked_sw("alu_or", 6, 76, a | b);
    emit(enc_r(fn_slt, 1, 2, 7));
    emit_checked_sw("alu_slt", 7, 80, slt_ab);     // pause follows this one
    emit(enc_r(fn_slt, 2, 1, 7));
    emit_checked_sw("alu_slt_rev", 7, 84, slt_ba);
    emit(enc_i(op_addiu, 1, 8, -100));
    emit_checked_sw("alu_addiu_neg", 8, 88, a + 32'hffff_ff9c);
    emit(enc_r(fn_addu, 1, 2, 9));
    emit(enc_r(fn_addu, 9, 1, 10));                // back to back
    emit(enc_r(fn_addu, 9, 10, 11));               // r9 at distance two
    emit_checked_sw("fwd_back_to_back", 11, 92, sum + r10);
    emit_checked_sw("fwd_regfile_bypass", 10, 96, r10);
    emit(enc_i(op_lw, 0, 12, 8));
    emit(enc_r(fn_addu, 12, 1, 13));               // load-use stall
    emit_checked_sw("load_use", 13, 100, data_words[2] + a);
    emit(enc_r(fn_addu, 1, 2, 14));
    emit(enc_i(op_beq, 3, 14, 3));                 // taken, r14 forwarded
    emit_checked_sw("beq_delay_slot", 3, 104, sum);
    emit(enc_i(op_sw, 0, 4, 108));                 // squashed
    emit(enc_i(op_sw, 0, 5, 112));
    emit_checked_sw("beq_target", 6, 116, a | b);
    emit(enc_i(op_bne, 3, 14, 6));                 // not taken
    emit_checked_sw("bne_delay_slot", 7, 120, slt_ba);
    emit_checked_sw("bne_fall_through", 8, 124, a + 32'hffff_ff9c);
    emit({op_j, 26'(base_word + 38)});
    emit_checked_sw("j_delay_slot", 9, 128, sum);
    emit(enc_i(op_sw, 0, 10, 132));                // squashed
    emit(enc_i(op_sw, 0, 4, 140));
    emit_checked_sw("j_target", 11, 136, sum + r10);
    emit({op_j, 26'(base_word + 39)});             // park here
    emit(32'h0000_0000);
  endtask

  task automatic wait_reset_release(input int limit, output bit ok);
    int cycles;
    cycles = 0;
    while (reset && cycles < limit) begin
      @(posedge clk);
      cycles++;
    end
    ok = !reset;
    if (!ok) $display("timeout while waiting for reset release");
  endtask

  task automatic wait_stores(input int count, input int limit, output bit ok);
    int cycles;
    cycles = 0;
    while (head < count && cycles < limit) begin
      @(posedge clk);
      cycles++;
    end
    ok = (head >= count);
    if (!ok) $display("timeout while waiting for store %0d, %0d arrived", count, head);
  endtask

  initial begin : main
    int pause_len;
    bit ok;
    void'($urandom(32'hdb93));
    for (int i = 0; i < 8; i++) data_words[i] = $urandom;
    pause_len = 2 + int'($urandom % 8);
    build_program();
    wait_reset_release(20, ok);
    if (ok) wait_stores(5, 200, ok);
    if (ok) begin
      run <= 1'b0;
      repeat (pause_len) @(posedge clk);
      run <= 1'b1;
      wait_stores(tail, 400, ok);
    end
    if (ok) repeat (12) @(posedge clk);            // room for a stray store
    else timed_out = 1'b1;
    $display("errors: %0d value, %0d other, %0d timeout; %0d of %0d stores, pause %0d",
             value_errors, other_errors, timed_out, head, tail, pause_len);
    if (value_errors == 0 && other_errors == 0 && !timed_out && head == tail) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

/* cpu_core.f */
isa_pkg.sv
pipe_pkg.sv
hazard_if.sv
regfile.sv
fetch_stage.sv
decode_stage.sv
execute_stage.sv
writeback_stage.sv
hazard_unit.sv
cpu_core.sv
tb_clock.sv
tb_cpu_core.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

log=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f cpu_core.f --top-module tb_cpu_core --Mdir obj_dir
./obj_dir/Vtb_cpu_core | tee "$log"

if grep -q "^TB PASSED$" "$log"; then
  echo "simulation passed"
  exit 0
fi
echo "simulation failed"
exit 1
